/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mini_tile
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: sim clean

# Run the testbench; status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+rtl
rtl/mini_tile_pkg.sv
rtl/phy_regfile.sv
rtl/alu_lane.sv
rtl/reorder_buffer.sv
rtl/tile_dispatch.sv
rtl/mini_tile.sv
test/tb_clk_gen.sv
test/tb_mini_tile.sv

/* rtl/alu_lane.sv */
/*
 * Integer execution lane
 * Single-cycle logic and arithmetic, multi-cycle MUL, done report per op
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module alu_lane import mini_tile_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_iss_valid,
  input  op_e      i_iss_op,
  input  xdata_t   i_iss_a,
  input  xdata_t   i_iss_b,
  input  rob_tag_t i_iss_tag,
  output logic     o_busy,
  output logic     o_done_valid,
  output rob_tag_t o_done_tag,
  output xdata_t   o_done_data
);

  localparam int CNT_W = $clog2(`TILE_MUL_LAT + 1);

  logic [CNT_W-1:0] r_cnt;
  logic             r_done_valid;
  rob_tag_t         r_done_tag;
  xdata_t           r_done_data;
  xdata_t           r_mul_a;
  xdata_t           r_mul_b;

  logic             w_is_mul;
  logic             w_mul_last;
  xdata_t           w_result;
  xdata_t           w_product;

  assign w_is_mul   = (i_iss_op == OP_MUL);
  assign w_mul_last = (r_cnt == CNT_W'(1));
  // Low half of the product, from the held operands
  assign w_product  = r_mul_a * r_mul_b;

  always_comb begin
    case (i_iss_op)
      OP_ADD, OP_ADDI: w_result = i_iss_a + i_iss_b;
      OP_SUB:          w_result = i_iss_a - i_iss_b;
      OP_AND:          w_result = i_iss_a & i_iss_b;
      OP_OR:           w_result = i_iss_a | i_iss_b;
      OP_XOR, OP_XORI: w_result = i_iss_a ^ i_iss_b;
      default:         w_result = '0;
    endcase
  end

  // ------------------------------
  // MUL counter and done pulse
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_cnt        <= '0;
      r_done_valid <= 1'b0;
    end else begin
      if (i_iss_valid && w_is_mul) begin
        r_cnt <= CNT_W'(`TILE_MUL_LAT - 1);
      end else if (r_cnt != '0) begin
        r_cnt <= r_cnt - 1'b1;
      end
      r_done_valid <= (i_iss_valid && !w_is_mul) || w_mul_last;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_iss_valid) begin
      r_done_tag  <= i_iss_tag;
      r_done_data <= w_result;
      r_mul_a     <= i_iss_a;
      r_mul_b     <= i_iss_b;
    end else if (w_mul_last) begin
      r_done_data <= w_product;
    end
  end

  assign o_busy       = (r_cnt != '0);
  assign o_done_valid = r_done_valid;
  assign o_done_tag   = r_done_tag;
  assign o_done_data  = r_done_data;

endmodule

/* rtl/mini_tile.sv */
/*
 * Mini tile top
 * Dispatcher, integer lanes, reorder buffer and register file
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module mini_tile import mini_tile_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_req,
  input  inst_u    i_inst,
  output logic     o_ack,
  output logic     o_cmt_valid,
  output reg_idx_t o_cmt_rd,
  output xdata_t   o_cmt_data
);

  // ------------------------------
  // Tile wires
  // ------------------------------
  reg_idx_t                  w_rs1;
  reg_idx_t                  w_rs2;
  xdata_t                    w_rs1_data;
  xdata_t                    w_rs2_data;
  logic                      w_full;
  rob_tag_t                  w_alloc_tag;
  logic                      w_alloc_valid;
  reg_idx_t                  w_alloc_rd;
  rob_tag_t                  w_cmt_tag;
  logic [`TILE_LANE_NUM-1:0] w_lane_busy;
  logic [`TILE_LANE_NUM-1:0] w_iss_valid;
  op_e                       w_iss_op;
  xdata_t                    w_iss_a;
  xdata_t                    w_iss_b;
  rob_tag_t                  w_iss_tag;
  logic                      w_done_valid [`TILE_LANE_NUM];
  rob_tag_t                  w_done_tag   [`TILE_LANE_NUM];
  xdata_t                    w_done_data  [`TILE_LANE_NUM];

  tile_dispatch u_dispatch (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_inst       (i_inst),
    .o_ack        (o_ack),
    .o_rs1        (w_rs1),
    .o_rs2        (w_rs2),
    .i_rs1_data   (w_rs1_data),
    .i_rs2_data   (w_rs2_data),
    .i_full       (w_full),
    .i_alloc_tag  (w_alloc_tag),
    .o_alloc_valid(w_alloc_valid),
    .o_alloc_rd   (w_alloc_rd),
    .i_lane_busy  (w_lane_busy),
    .o_iss_valid  (w_iss_valid),
    .o_iss_op     (w_iss_op),
    .o_iss_a      (w_iss_a),
    .o_iss_b      (w_iss_b),
    .o_iss_tag    (w_iss_tag),
    .i_cmt_valid  (o_cmt_valid),
    .i_cmt_tag    (w_cmt_tag),
    .i_cmt_rd     (o_cmt_rd)
  );

  generate for (genvar g = 0; g < `TILE_LANE_NUM; g++) begin : lane_loop
    alu_lane u_lane (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_iss_valid (w_iss_valid[g]),
      .i_iss_op    (w_iss_op),
      .i_iss_a     (w_iss_a),
      .i_iss_b     (w_iss_b),
      .i_iss_tag   (w_iss_tag),
      .o_busy      (w_lane_busy[g]),
      .o_done_valid(w_done_valid[g]),
      .o_done_tag  (w_done_tag[g]),
      .o_done_data (w_done_data[g])
    );
  end
  endgenerate

  reorder_buffer u_rob (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_alloc_valid(w_alloc_valid),
    .i_alloc_rd   (w_alloc_rd),
    .o_alloc_tag  (w_alloc_tag),
    .o_full       (w_full),
    .i_done_valid (w_done_valid),
    .i_done_tag   (w_done_tag),
    .i_done_data  (w_done_data),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt_tag    (w_cmt_tag),
    .o_cmt_rd     (o_cmt_rd),
    .o_cmt_data   (o_cmt_data)
  );

  phy_regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_rs1     (w_rs1),
    .i_rs2     (w_rs2),
    .o_rs1_data(w_rs1_data),
    .o_rs2_data(w_rs2_data),
    .i_wr_valid(o_cmt_valid),
    .i_wr_rd   (o_cmt_rd),
    .i_wr_data (o_cmt_data)
  );

endmodule

/* rtl/mini_tile_cfg.svh */
/*
 * Mini tile configuration
 * Data width, register count, reorder buffer depth, lane count and MUL latency
 */

`ifndef MINI_TILE_CFG_SVH
`define MINI_TILE_CFG_SVH

`define TILE_XLEN      16
`define TILE_REG_NUM   16
`define TILE_ROB_DEPTH 8
`define TILE_LANE_NUM  2

// Cycles from issue to done for MUL, at least 2
`define TILE_MUL_LAT   3

`endif

/* rtl/mini_tile_pkg.sv */
/*
 * Mini tile package
 * Opcodes, the two views of the instruction word and shared data types
 */

`include "mini_tile_cfg.svh"

package mini_tile_pkg;

  typedef logic [`TILE_XLEN-1:0]               xdata_t;
  typedef logic [3:0]                          reg_idx_t;
  typedef logic [$clog2(`TILE_ROB_DEPTH)-1:0] rob_tag_t;

  // Codes not listed are illegal
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MUL  = 4'd5,
    OP_ADDI = 4'd8,
    OP_XORI = 4'd9
  } op_e;

  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } inst_r_t;

  typedef struct packed {
    op_e               op;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    logic signed [3:0] imm;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

endpackage

/* rtl/phy_regfile.sv */
/*
 * Integer register file
 * Two combinational read ports, one write port fed by commit
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module phy_regfile import mini_tile_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output xdata_t   o_rs1_data,
  output xdata_t   o_rs2_data,
  input  logic     i_wr_valid,
  input  reg_idx_t i_wr_rd,
  input  xdata_t   i_wr_data
);

  xdata_t r_regs [`TILE_REG_NUM];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < `TILE_REG_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else if (i_wr_valid && (i_wr_rd != '0)) begin
      r_regs[i_wr_rd] <= i_wr_data;
    end
  end

  // r0 is hardwired to zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

endmodule

/* rtl/reorder_buffer.sv */
/*
 * Reorder buffer
 * Tracks in-flight results, collects lane done reports, commits in order
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module reorder_buffer import mini_tile_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_alloc_valid,
  input  reg_idx_t i_alloc_rd,
  output rob_tag_t o_alloc_tag,
  output logic     o_full,
  input  logic     i_done_valid [`TILE_LANE_NUM],
  input  rob_tag_t i_done_tag   [`TILE_LANE_NUM],
  input  xdata_t   i_done_data  [`TILE_LANE_NUM],
  output logic     o_cmt_valid,
  output rob_tag_t o_cmt_tag,
  output reg_idx_t o_cmt_rd,
  output xdata_t   o_cmt_data
);

  localparam int CNT_W = $clog2(`TILE_ROB_DEPTH + 1);

  rob_tag_t                   r_head;
  rob_tag_t                   r_tail;
  logic [CNT_W-1:0]           r_cnt;
  logic [`TILE_ROB_DEPTH-1:0] r_done;
  reg_idx_t                   r_rd   [`TILE_ROB_DEPTH];
  xdata_t                     r_data [`TILE_ROB_DEPTH];

  logic                       w_cmt;

  // ------------------------------
  // Status
  // ------------------------------
  assign o_alloc_tag = r_tail;
  assign o_full      = (r_cnt == CNT_W'(`TILE_ROB_DEPTH));

  // Head leaves once its result is in
  assign w_cmt = (r_cnt != '0) && r_done[r_head];

  assign o_cmt_valid = w_cmt;
  assign o_cmt_tag   = r_head;
  assign o_cmt_rd    = r_rd[r_head];
  assign o_cmt_data  = r_data[r_head];

  // ------------------------------
  // Pointers and done bits
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_head <= '0;
      r_tail <= '0;
      r_cnt  <= '0;
      r_done <= '0;
    end else begin
      if (i_alloc_valid) begin
        r_done[r_tail] <= 1'b0;
        r_tail         <= r_tail + 1'b1;
      end

      // Lanes never share a tag
      for (int l = 0; l < `TILE_LANE_NUM; l++) begin
        if (i_done_valid[l]) begin
          r_done[i_done_tag[l]] <= 1'b1;
        end
      end

      if (w_cmt) begin
        r_done[r_head] <= 1'b0;
        r_head         <= r_head + 1'b1;
      end

      r_cnt <= r_cnt + CNT_W'(i_alloc_valid) - CNT_W'(w_cmt);
    end
  end

  // ------------------------------
  // Entry payload
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_alloc_valid) begin
      r_rd[r_tail] <= i_alloc_rd;
    end
    for (int l = 0; l < `TILE_LANE_NUM; l++) begin
      if (i_done_valid[l]) begin
        r_data[i_done_tag[l]] <= i_done_data[l];
      end
    end
  end

endmodule

/* rtl/tile_dispatch.sv */
/*
 * Tile dispatcher
 * Four-phase intake, scoreboard, operand read and issue to the lowest free lane
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module tile_dispatch import mini_tile_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_req,
  input  inst_u                     i_inst,
  output logic                      o_ack,
  output reg_idx_t                  o_rs1,
  output reg_idx_t                  o_rs2,
  input  xdata_t                    i_rs1_data,
  input  xdata_t                    i_rs2_data,
  input  logic                      i_full,
  input  rob_tag_t                  i_alloc_tag,
  output logic                      o_alloc_valid,
  output reg_idx_t                  o_alloc_rd,
  input  logic [`TILE_LANE_NUM-1:0] i_lane_busy,
  output logic [`TILE_LANE_NUM-1:0] o_iss_valid,
  output op_e                       o_iss_op,
  output xdata_t                    o_iss_a,
  output xdata_t                    o_iss_b,
  output rob_tag_t                  o_iss_tag,
  input  logic                      i_cmt_valid,
  input  rob_tag_t                  i_cmt_tag,
  input  reg_idx_t                  i_cmt_rd
);

  logic                      r_ack;
  logic [`TILE_REG_NUM-1:0]  r_pend;
  rob_tag_t                  r_tag [`TILE_REG_NUM];

  logic                      w_is_imm;
  logic                      w_src_pend;
  logic [`TILE_LANE_NUM-1:0] w_lane_free;
  logic [`TILE_LANE_NUM-1:0] w_sel_oh;
  logic                      w_accept;
  reg_idx_t                  w_rd;
  xdata_t                    w_imm_ext;

  // ------------------------------
  // Decode
  // ------------------------------
  assign w_is_imm  = (i_inst.r.op == OP_ADDI) || (i_inst.r.op == OP_XORI);
  assign w_rd      = i_inst.r.rd;
  assign w_imm_ext = {{(`TILE_XLEN-4){i_inst.i.imm[3]}}, i_inst.i.imm};

  assign o_rs1 = i_inst.r.rs1;
  assign o_rs2 = i_inst.r.rs2;

  // rs2 field holds the immediate in the I form
  assign w_src_pend = r_pend[i_inst.r.rs1] || (!w_is_imm && r_pend[i_inst.r.rs2]);

  // Lowest set bit of the free mask
  assign w_lane_free = ~i_lane_busy;
  assign w_sel_oh    = w_lane_free & (~w_lane_free + 1'b1);

  assign w_accept = i_req && !r_ack && !i_full && (|w_lane_free) && !w_src_pend;

  // ------------------------------
  // Allocate and issue
  // ------------------------------
  assign o_alloc_valid = w_accept;
  assign o_alloc_rd    = w_rd;

  assign o_iss_valid = w_accept ? w_sel_oh : '0;
  assign o_iss_op    = i_inst.r.op;
  assign o_iss_a     = i_rs1_data;
  assign o_iss_b     = w_is_imm ? w_imm_ext : i_rs2_data;
  assign o_iss_tag   = i_alloc_tag;

  assign o_ack = r_ack;

  // ------------------------------
  // Handshake and scoreboard
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ack  <= 1'b0;
      r_pend <= '0;
    end else begin
      if (w_accept) begin
        r_ack <= 1'b1;
      end else if (r_ack && !i_req) begin
        r_ack <= 1'b0;
      end

      // Only the newest writer clears the bit
      if (i_cmt_valid && (r_tag[i_cmt_rd] == i_cmt_tag)) begin
        r_pend[i_cmt_rd] <= 1'b0;
      end
      // r0 never waits
      if (w_accept && (w_rd != '0)) begin
        r_pend[w_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_tag[w_rd] <= i_alloc_tag;
    end
  end

endmodule

/* test/tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * 20 ns clock, active-low reset held for two cycles
 */

`timescale 1ns/1ns

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD = 10;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Release on a falling edge, after two rising edges in reset
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

/* test/tb_mini_tile.sv */
/*
 * Mini tile testbench
 * Four-phase instruction stimulus, reference register model, in-order commit check
 */

`timescale 1ns/1ns
`include "mini_tile_cfg.svh"

module tb_mini_tile import mini_tile_pkg::*; ();

  // About 230 instructions, 20 cycles each at worst
  localparam int NUM_INST       = 230;
  localparam int CYC_PER_INST   = 20;
  localparam int TIMEOUT_CYCLES = NUM_INST * CYC_PER_INST + 400;
  localparam int NUM_RANDOM     = 200;

  logic     clk;
  logic     rst_n;
  logic     req;
  inst_u    inst_word;
  logic     ack;
  logic     cmt_valid;
  reg_idx_t cmt_rd;
  xdata_t   cmt_data;

  xdata_t      model_regs [`TILE_REG_NUM];
  reg_idx_t    exp_rd_q[$];
  xdata_t      exp_data_q[$];
  string       exp_name_q[$];
  logic [31:0] lfsr_state = 32'h22d175b2;
  int          cycle_cnt  = 0;
  logic        prev_ack   = 1'b0;
  logic        prev_req   = 1'b0;

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  mini_tile mini_tile_i (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_req      (req),
    .i_inst     (inst_word),
    .o_ack      (ack),
    .o_cmt_valid(cmt_valid),
    .o_cmt_rd   (cmt_rd),
    .o_cmt_data (cmt_data)
  );

  // ------------------------------
  // Error reporting
  // ------------------------------
  task automatic report_mismatch(input string test_name, input string field,
                                 input logic [15:0] exp_val, input logic [15:0] act_val);
    $display("[FAIL] %s: %s expected 0x%h actual 0x%h", test_name, field, exp_val, act_val);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // ------------------------------
  // Random bits and instruction builders
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits       = {bits[14:0], lfsr_state[31]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  function automatic inst_u reg_form(input logic [3:0] op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2);
    inst_u w;
    w.r.op  = op_e'(op);
    w.r.rd  = rd;
    w.r.rs1 = rs1;
    w.r.rs2 = rs2;
    return w;
  endfunction

  function automatic inst_u imm_form(input logic [3:0] op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [3:0] imm);
    inst_u w;
    w.i.op  = op_e'(op);
    w.i.rd  = rd;
    w.i.rs1 = rs1;
    w.i.imm = imm;
    return w;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  // r0 is never written, so it reads as zero
  function automatic xdata_t ref_apply(input inst_u inst);
    xdata_t a;
    xdata_t b;
    xdata_t res;
    a = model_regs[inst.r.rs1];
    if ((inst.i.op == OP_ADDI) || (inst.i.op == OP_XORI)) begin
      b = {{(`TILE_XLEN-4){inst.i.imm[3]}}, inst.i.imm};
    end else begin
      b = model_regs[inst.r.rs2];
    end
    case (inst.r.op)
      OP_ADD, OP_ADDI: res = a + b;
      OP_SUB:          res = a - b;
      OP_AND:          res = a & b;
      OP_OR:           res = a | b;
      OP_XOR, OP_XORI: res = a ^ b;
      OP_MUL:          res = a * b;
      default:         res = '0;
    endcase
    if (inst.r.rd != '0) begin
      model_regs[inst.r.rd] = res;
    end
    return res;
  endfunction

  // Called on a falling edge with o_ack low
  task automatic send_inst(input inst_u inst, input string test_name);
    xdata_t res;
    res = ref_apply(inst);
    exp_rd_q.push_back(inst.r.rd);
    exp_data_q.push_back(res);
    exp_name_q.push_back(test_name);
    req       = 1'b1;
    inst_word = inst;
    while (!ack) @(negedge clk);
    req = 1'b0;
    while (ack) @(negedge clk);
  endtask

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge clk) begin : compare_commits
    string    name;
    reg_idx_t exp_rd;
    xdata_t   exp_data;
    if (rst_n && cmt_valid) begin
      assert (exp_rd_q.size() != 0)
        else report_error("A commit arrived with no instruction outstanding");
      name     = exp_name_q.pop_front();
      exp_rd   = exp_rd_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (cmt_rd == exp_rd) else report_mismatch(name, "commit rd", 16'(exp_rd), 16'(cmt_rd));
      assert (cmt_data == exp_data) else report_mismatch(name, "commit data", exp_data, cmt_data);
    end
  end

  always @(posedge clk) begin : check_handshake
    if (rst_n) begin
      if (prev_ack && !ack) begin
        assert (!prev_req) else report_error("o_ack fell while i_req was still high");
      end
      if (!prev_ack && ack) begin
        assert (prev_req) else report_error("o_ack rose with no request pending");
      end
    end
    prev_ack = ack;
    prev_req = req;
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run passed %0d cycles with %0d commits outstanding",
               TIMEOUT_CYCLES, exp_rd_q.size());
      $display("tests failed");
      $fatal(1);
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    inst_u rnd;
    req       = 1'b0;
    inst_word = '0;
    for (int r = 0; r < `TILE_REG_NUM; r++) begin
      model_regs[r] = '0;
    end
    @(posedge rst_n);

    repeat (4) begin
      @(negedge clk);
      assert (!ack && !cmt_valid) else report_error("Output active while idle after reset");
    end

    // Scoreboard stall on each step
    send_inst(imm_form(OP_ADDI, 4'd1, 4'd0, 4'd5), "dep_chain");
    send_inst(reg_form(OP_ADD, 4'd2, 4'd1, 4'd1), "dep_chain");
    send_inst(reg_form(OP_SUB, 4'd3, 4'd2, 4'd1), "dep_chain");
    send_inst(reg_form(OP_XOR, 4'd4, 4'd3, 4'd2), "dep_chain");

    // XORI on the second lane reports done together with the MUL ahead of it
    send_inst(imm_form(OP_ADDI, 4'd5, 4'd0, 4'h7), "mul_order");
    send_inst(reg_form(OP_MUL, 4'd6, 4'd5, 4'd3), "mul_order");
    send_inst(imm_form(OP_XORI, 4'd7, 4'd1, 4'hA), "mul_order");
    send_inst(reg_form(OP_OR, 4'd8, 4'd2, 4'd1), "mul_order");
    send_inst(reg_form(OP_MUL, 4'd9, 4'd6, 4'd6), "mul_order");

    // Write-after-write on r10, then read it back
    send_inst(reg_form(OP_MUL, 4'd10, 4'd5, 4'd5), "last_write");
    send_inst(imm_form(OP_ADDI, 4'd10, 4'd0, 4'h1), "last_write");
    send_inst(imm_form(OP_ADDI, 4'd10, 4'd10, 4'h2), "last_write");
    send_inst(imm_form(OP_ADDI, 4'd10, 4'd0, 4'hF), "last_write");
    send_inst(reg_form(OP_ADD, 4'd11, 4'd10, 4'd0), "last_write");

    send_inst(imm_form(OP_ADDI, 4'd0, 4'd1, 4'h3), "r0_illegal");
    send_inst(reg_form(OP_ADD, 4'd12, 4'd0, 4'd1), "r0_illegal");
    for (int c = 6; c < 16; c++) begin
      if ((c != 8) && (c != 9)) begin
        send_inst(reg_form(4'(c), 4'd13, 4'd1, 4'd2), "r0_illegal");
      end
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = rand_bits(16);
      send_inst(rnd, $sformatf("random_%0d", n));
    end

    // Drain, then a quiet window for stray commits
    while (exp_rd_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule
